// File: design/sprite_pkg.sv
package sprite_pkg;

    // chart geometry
    localparam int LANES       = 4;
    localparam int CHART_DEPTH = 16;
    localparam int SLOTS       = 4;
    localparam int TIME_W      = 14;

    localparam logic [1:0] NOTE_SHORT = 2'b01;

    // note motion, row = OFFSET_Y - MV_SPEED * (note time - now)
    localparam int MV_SPEED    = 14;
    localparam int OFFSET_Y    = 454;
    localparam int SCREEN_ROWS = 480;

    // sprite and frame buffer layout
    localparam int NOTE_ROWS  = 12;
    localparam int NOTE_WORDS = 3;
    localparam int ROW_WORDS  = 40;

    localparam logic [21:0] LANE_COL [LANES] = '{22'd1, 22'd4, 22'd7, 22'd10};

    localparam logic [6:0]  SPRITE_BASE_DK = 7'd0;
    localparam logic [6:0]  SPRITE_BASE_FJ = 7'd36;
    localparam logic [21:0] FRAME_BASE0    = 22'h100000;
    localparam logic [21:0] FRAME_BASE1    = 22'h200000;
    localparam logic [7:0]  TRANSPARENT    = 8'hFF;

    // judgement thresholds, in time units before the note
    localparam int WIN_GOOD    = 34;
    localparam int WIN_GREAT   = 22;
    localparam int WIN_PERFECT = 14;

    localparam logic [1:0] GRADE_NONE    = 2'd0;
    localparam logic [1:0] GRADE_PERFECT = 2'd1;
    localparam logic [1:0] GRADE_GREAT   = 2'd2;
    localparam logic [1:0] GRADE_GOOD    = 2'd3;

    // blit FSM states
    localparam logic [2:0] ST_IDLE     = 3'd0;
    localparam logic [2:0] ST_WAIT_BUS = 3'd1;
    localparam logic [2:0] ST_EXAMINE  = 3'd2;
    localparam logic [2:0] ST_READ     = 3'd3;
    localparam logic [2:0] ST_FETCH    = 3'd4;
    localparam logic [2:0] ST_WRITE    = 3'd5;
    localparam logic [2:0] ST_PAUSE    = 3'd6;

    typedef union packed {
        logic [127:0]     flat;
        logic [15:0][7:0] bytes;
    } pixel_word_u;

endpackage

// File: design/note_tracker.sv
`timescale 1ns/1ps

module note_tracker
    import sprite_pkg::*;
(
    input  logic                        clk,
    input  logic                        reset,
    input  logic                        new_frame,
    input  logic [15:0]                 un_time,
    input  logic [3:0]                  keys,
    input  logic                        chart_wr,
    input  logic [5:0]                  chart_addr,
    input  logic [15:0]                 chart_data,
    output logic                        judge_valid,
    output logic [7:0]                  judge_grade,
    output logic [TIME_W-1:0]           note_time [LANES][SLOTS],
    output logic [LANES-1:0][SLOTS-1:0] note_present
);

    logic [15:0]       chart [LANES][CHART_DEPTH];
    logic [3:0]        ptr [LANES];
    logic [LANES-1:0]  key_prev;
    logic [LANES-1:0]  lane_key;
    logic [LANES-1:0]  press;
    logic [1:0]        grade [LANES];
    logic [TIME_W-1:0] cur_time;

    function automatic logic [1:0] judge(
        input logic              present,
        input logic              pressed,
        input logic [TIME_W-1:0] delta
    );
        logic [1:0] g;
        if (!present)
            g = GRADE_NONE;
        else if (delta == '0)
            g = GRADE_GOOD;
        else if (!pressed)
            g = GRADE_NONE;
        // late notes wrap to large deltas and fall out here
        else if (delta > WIN_GOOD)
            g = GRADE_NONE;
        else if (delta > WIN_GREAT)
            g = GRADE_GOOD;
        else if (delta > WIN_PERFECT)
            g = GRADE_GREAT;
        else
            g = GRADE_PERFECT;
        return g;
    endfunction

    assign cur_time = un_time[TIME_W-1:0];

    // lane in the upper address bits
    always_ff @(posedge clk)
    begin
        if (chart_wr)
            chart[chart_addr[5:4]][chart_addr[3:0]] <= chart_data;
    end

    for (genvar l = 0; l < LANES; l++)
    begin : g_lane
        logic [15:0]       head;
        logic [TIME_W-1:0] delta;

        // keys bit 3 is lane d
        assign lane_key[l] = keys[LANES-1-l];
        assign press[l]    = lane_key[l] && !key_prev[l];

        assign head     = chart[l][ptr[l]];
        assign delta    = head[TIME_W-1:0] - cur_time;
        assign grade[l] = judge(head[TIME_W+1:TIME_W] == NOTE_SHORT, press[l], delta);

        for (genvar s = 0; s < SLOTS; s++)
        begin : g_slot
            logic [4:0]  idx;
            logic [15:0] entry;

            assign idx   = {1'b0, ptr[l]} + 5'(s);
            assign entry = chart[l][idx[3:0]];

            assign note_time[l][s]    = entry[TIME_W-1:0];
            // nothing beyond the end of the chart
            assign note_present[l][s] = !idx[4] && entry[TIME_W+1:TIME_W] == NOTE_SHORT;
        end
    end

    always_ff @(posedge clk or posedge reset)
    begin
        if (reset)
        begin
            judge_valid <= 1'b0;
            judge_grade <= '0;
            key_prev    <= '0;
            for (int l = 0; l < LANES; l++)
                ptr[l] <= '0;
        end
        else
        begin
            judge_valid <= new_frame;
            if (new_frame)
            begin
                key_prev <= lane_key;
                for (int l = 0; l < LANES; l++)
                begin
                    judge_grade[2*(LANES-1-l) +: 2] <= grade[l];
                    if (grade[l] != GRADE_NONE)
                        ptr[l] <= ptr[l] + 4'd1;
                end
            end
        end
    end

endmodule

// File: design/sprite_store.sv
`timescale 1ns/1ps

module sprite_store
    import sprite_pkg::*;
(
    input  logic         clk,
    input  logic         ram_wr,
    input  logic [6:0]   ram_wraddr,
    input  logic [127:0] ram_data,
    input  logic [6:0]   sprite_rdaddr,
    output logic [127:0] sprite_word
);

    // two sprites, d/k first then f/j
    logic [127:0] mem [SPRITE_BASE_FJ + NOTE_ROWS * NOTE_WORDS];

    always_ff @(posedge clk)
    begin
        if (ram_wr && ram_wraddr < SPRITE_BASE_FJ + NOTE_ROWS * NOTE_WORDS)
            mem[ram_wraddr] <= ram_data;
    end

    always_ff @(posedge clk)
    begin
        sprite_word <= mem[sprite_rdaddr];
    end

endmodule

// File: design/blit_sequencer.sv
`timescale 1ns/1ps

module blit_sequencer
    import sprite_pkg::*;
(
    input  logic                        clk,
    input  logic                        reset,
    input  logic                        new_frame,
    input  logic                        frame_flip,
    input  logic [15:0]                 un_time,
    input  logic                        sdram_wait,
    input  logic                        sdram_ac,
    input  logic [TIME_W-1:0]           note_time [LANES][SLOTS],
    input  logic [LANES-1:0][SLOTS-1:0] note_present,
    input  logic [127:0]                sprite_word,
    output logic [6:0]                  sprite_rdaddr,
    output logic                        sdram_wr,
    output logic [21:0]                 sdram_addr,
    output logic [127:0]                sdram_data,
    output logic [15:0]                 sdram_be,
    output logic                        busy,
    output logic                        done
);

    logic [2:0]         state;
    // {lane, slot}, top bit set once every note is visited
    logic [4:0]         note_idx;
    logic [1:0]         lane;
    logic [1:0]         slot;
    logic [3:0]         row;
    logic [1:0]         col;
    logic               resume_exam;
    logic               last_word;
    logic signed [31:0] delta;
    logic signed [31:0] pos_y;
    logic               visible;
    logic [21:0]        note_addr;
    logic [6:0]         spr_base;
    logic [21:0]        row_addr;
    pixel_word_u        word_q;

    assign lane = note_idx[3:2];
    assign slot = note_idx[1:0];

    assign delta = $signed({18'd0, note_time[lane][slot]})
                 - $signed({18'd0, un_time[TIME_W-1:0]});
    assign pos_y = OFFSET_Y - MV_SPEED * delta;

    // whole sprite must fit on screen
    assign visible = note_present[lane][slot] && pos_y >= 0
                  && pos_y <= SCREEN_ROWS - NOTE_ROWS;

    assign note_addr = (frame_flip ? FRAME_BASE1 : FRAME_BASE0)
                     + 22'(pos_y[8:0]) * 22'(ROW_WORDS) + LANE_COL[lane];

    // f and j share one sprite, d and k the other
    assign spr_base  = (lane == 2'd1 || lane == 2'd2) ? SPRITE_BASE_FJ : SPRITE_BASE_DK;
    assign last_word = row == 4'(NOTE_ROWS - 1) && col == 2'(NOTE_WORDS - 1);

    always_ff @(posedge clk or posedge reset)
    begin
        if (reset)
        begin
            state       <= ST_IDLE;
            note_idx    <= '0;
            row         <= '0;
            col         <= '0;
            resume_exam <= 1'b0;
            done        <= 1'b0;
        end
        else
        begin
            if (new_frame)
                done <= 1'b0;
            case (state)
                ST_IDLE:
                    if (new_frame)
                    begin
                        note_idx <= '0;
                        state    <= ST_WAIT_BUS;
                    end
                ST_WAIT_BUS:
                    if (!sdram_wait)
                        state <= ST_EXAMINE;
                ST_EXAMINE:
                    if (note_idx[4])
                    begin
                        done  <= 1'b1;
                        state <= ST_IDLE;
                    end
                    else if (visible)
                    begin
                        row   <= '0;
                        col   <= '0;
                        state <= ST_READ;
                    end
                    else
                        note_idx <= note_idx + 5'd1;
                ST_READ:
                    state <= ST_FETCH;
                ST_FETCH:
                    state <= ST_WRITE;
                ST_WRITE:
                    if (sdram_ac)
                    begin
                        if (col == 2'(NOTE_WORDS - 1))
                        begin
                            col <= '0;
                            row <= row + 4'd1;
                        end
                        else
                            col <= col + 2'd1;
                        if (last_word)
                            note_idx <= note_idx + 5'd1;
                        resume_exam <= last_word;
                        if (sdram_wait)
                            state <= ST_PAUSE;
                        else if (last_word)
                            state <= ST_EXAMINE;
                        else
                            state <= ST_READ;
                    end
                ST_PAUSE:
                    if (!sdram_wait)
                        state <= resume_exam ? ST_EXAMINE : ST_READ;
                default:
                    state <= ST_IDLE;
            endcase
        end
    end

    // sprite words are stored row by row, so the read address just counts up
    always_ff @(posedge clk)
    begin
        case (state)
            ST_EXAMINE:
            begin
                row_addr      <= note_addr;
                sprite_rdaddr <= spr_base;
            end
            ST_FETCH:
            begin
                word_q.flat <= sprite_word;
                sdram_addr  <= row_addr + 22'(col);
            end
            ST_WRITE:
                if (sdram_ac)
                begin
                    sprite_rdaddr <= sprite_rdaddr + 7'd1;
                    if (col == 2'(NOTE_WORDS - 1))
                        row_addr <= row_addr + 22'(ROW_WORDS);
                end
            default:
                ;
        endcase
    end

    assign sdram_wr   = state == ST_WRITE;
    assign busy       = state != ST_IDLE;
    assign sdram_data = word_q.flat;

    // transparent bytes leave the frame buffer untouched
    always_comb
    begin
        for (int i = 0; i < 16; i++)
            sdram_be[i] = word_q.bytes[i] != TRANSPARENT;
    end

endmodule

// File: design/note_draw_top.sv
`timescale 1ns/1ps

module note_draw_top
    import sprite_pkg::*;
(
    input  logic         clk,
    input  logic         reset,
    input  logic         new_frame,
    input  logic         frame_flip,
    input  logic [15:0]  un_time,
    input  logic [3:0]   keys,
    input  logic         chart_wr,
    input  logic [5:0]   chart_addr,
    input  logic [15:0]  chart_data,
    input  logic         ram_wr,
    input  logic [6:0]   ram_wraddr,
    input  logic [127:0] ram_data,
    input  logic         sdram_wait,
    input  logic         sdram_ac,
    output logic         sdram_wr,
    output logic [21:0]  sdram_addr,
    output logic [127:0] sdram_data,
    output logic [15:0]  sdram_be,
    output logic         busy,
    output logic         done,
    output logic         judge_valid,
    output logic [7:0]   judge_grade
);

    logic [TIME_W-1:0]           note_time [LANES][SLOTS];
    logic [LANES-1:0][SLOTS-1:0] note_present;
    logic [6:0]                  sprite_rdaddr;
    logic [127:0]                sprite_word;

    note_tracker u_tracker (
        .clk          (clk),
        .reset        (reset),
        .new_frame    (new_frame),
        .un_time      (un_time),
        .keys         (keys),
        .chart_wr     (chart_wr),
        .chart_addr   (chart_addr),
        .chart_data   (chart_data),
        .judge_valid  (judge_valid),
        .judge_grade  (judge_grade),
        .note_time    (note_time),
        .note_present (note_present)
    );

    sprite_store u_sprites (
        .clk           (clk),
        .ram_wr        (ram_wr),
        .ram_wraddr    (ram_wraddr),
        .ram_data      (ram_data),
        .sprite_rdaddr (sprite_rdaddr),
        .sprite_word   (sprite_word)
    );

    blit_sequencer u_blit (
        .clk           (clk),
        .reset         (reset),
        .new_frame     (new_frame),
        .frame_flip    (frame_flip),
        .un_time       (un_time),
        .sdram_wait    (sdram_wait),
        .sdram_ac      (sdram_ac),
        .note_time     (note_time),
        .note_present  (note_present),
        .sprite_word   (sprite_word),
        .sprite_rdaddr (sprite_rdaddr),
        .sdram_wr      (sdram_wr),
        .sdram_addr    (sdram_addr),
        .sdram_data    (sdram_data),
        .sdram_be      (sdram_be),
        .busy          (busy),
        .done          (done)
    );

endmodule

// File: tests/tb_tasks.svh
`ifndef TB_TASKS_SVH
`define TB_TASKS_SVH

task automatic check_value(input string what, input logic [127:0] got,
                           input logic [127:0] expected);
    if (got !== expected)
    begin
        $display("[FAIL] %0t ns: %s, got %h expected %h", $time, what, got, expected);
        $display("TEST FAIL");
        $fatal(1, "mismatch");
    end
endtask

function automatic logic [15:0] byte_enables(input logic [127:0] word);
    logic [15:0] be;
    for (int i = 0; i < 16; i++)
        be[i] = word[8*i +: 8] != 8'hFF;
    return be;
endfunction

function automatic logic [1:0] expected_grade(input int delta, input logic pressed);
    if (delta == 0)
        return GRADE_GOOD;
    if (!pressed || delta > WIN_GOOD)
        return GRADE_NONE;
    if (delta > WIN_GREAT)
        return GRADE_GOOD;
    if (delta > WIN_PERFECT)
        return GRADE_GREAT;
    return GRADE_PERFECT;
endfunction

// expected writes for one note (none when off screen)
task automatic add_expected(input int lane, input int t, input int now, input logic flip);
    int row;
    int base;
    int spr;
    logic [127:0] word;
    row  = OFFSET_Y - MV_SPEED * (t - now);
    base = flip ? FRAME_BASE1 : FRAME_BASE0;
    spr  = (lane == 1 || lane == 2) ? 36 : 0;
    if (row >= 0 && row <= SCREEN_ROWS - NOTE_ROWS)
    begin
        for (int r = 0; r < NOTE_ROWS; r++)
        begin
            for (int c = 0; c < NOTE_WORDS; c++)
            begin
                word = sprite_mem[spr + r * NOTE_WORDS + c];
                exp_addr.push_back(22'(base + (row + r) * ROW_WORDS + 1 + 3 * lane + c));
                exp_data.push_back(word);
                exp_be.push_back(byte_enables(word));
            end
        end
    end
endtask

task automatic compare_log();
    check_value("number of accepted writes", log_addr.size(), exp_addr.size());
    for (int i = 0; i < exp_addr.size(); i++)
    begin
        check_value($sformatf("address of word %0d", i), log_addr[i], exp_addr[i]);
        check_value($sformatf("data of word %0d", i), log_data[i], exp_data[i]);
        check_value($sformatf("byte enables of word %0d", i), log_be[i], exp_be[i]);
    end
endtask

task automatic clear_logs();
    log_addr.delete();
    log_data.delete();
    log_be.delete();
    exp_addr.delete();
    exp_data.delete();
    exp_be.delete();
endtask

task automatic apply_reset();
    @(negedge clk);
    reset = 1'b1;
    repeat (8) @(negedge clk);
    reset = 1'b0;
endtask

task automatic load_sprites();
    logic [7:0] b;
    for (int w = 0; w < SPRITE_WORDS; w++)
    begin
        for (int i = 0; i < 16; i++)
        begin
            b = 8'($urandom);
            // about a quarter of the bytes see through
            if ($urandom % 4 == 0)
                b = 8'hFF;
            sprite_mem[w][8*i +: 8] = b;
        end
        @(negedge clk);
        ram_wr     = 1'b1;
        ram_wraddr = 7'(w);
        ram_data   = sprite_mem[w];
    end
    @(negedge clk);
    ram_wr = 1'b0;
endtask

task automatic write_chart(input int lane, input int idx, input logic [1:0] kind, input int t);
    @(negedge clk);
    chart_wr   = 1'b1;
    chart_addr = 6'(lane * CHART_DEPTH + idx);
    chart_data = {kind, 14'(t)};
    @(negedge clk);
    chart_wr = 1'b0;
endtask

task automatic clear_chart();
    for (int i = 0; i < LANES * CHART_DEPTH; i++)
        write_chart(i / CHART_DEPTH, i % CHART_DEPTH, 2'b00, 0);
endtask

task automatic start_frame();
    @(negedge clk);
    new_frame = 1'b1;
    @(negedge clk);
    new_frame = 1'b0;
endtask

task automatic wait_done();
    while (!done)
        @(negedge clk);
endtask

task automatic reset_state_low();
    apply_reset();
    check_value("sdram_wr after reset", sdram_wr, 0);
    check_value("busy after reset", busy, 0);
    check_value("done after reset", done, 0);
    check_value("judge_valid after reset", judge_valid, 0);
endtask

task automatic single_note_frame();
    apply_reset();
    clear_chart();
    clear_logs();
    keys = '0;
    write_chart(1, 0, NOTE_SHORT, 100);
    un_time = 16'd90;
    add_expected(1, 100, 90, 1'b0);
    start_frame();
    check_value("busy once the frame starts", busy, 1);
    wait_done();
    check_value("busy after done", busy, 0);
    check_value("writes for one note", log_addr.size(), NOTE_ROWS * NOTE_WORDS);
    compare_log();
    repeat (3) @(negedge clk);
    check_value("done held until next frame", done, 1);
endtask

task automatic flipped_frame();
    apply_reset();
    clear_chart();
    clear_logs();
    write_chart(1, 0, NOTE_SHORT, 100);
    // in view but not a drawable type
    write_chart(0, 0, 2'b11, 95);
    // above the top of the screen
    write_chart(2, 0, NOTE_SHORT, 200);
    // already past the bottom
    write_chart(3, 0, NOTE_SHORT, 88);
    un_time    = 16'd90;
    frame_flip = 1'b1;
    for (int l = 1; l < LANES; l++)
        add_expected(l, l == 1 ? 100 : (l == 2 ? 200 : 88), 90, 1'b1);
    start_frame();
    wait_done();
    compare_log();
    frame_flip = 1'b0;
endtask

task automatic judge_case(input int delta, input logic edge_wanted);
    apply_reset();
    clear_chart();
    keys    = '0;
    un_time = 16'(1000 - delta);
    if (!edge_wanted)
    begin
        // empty lane frame only records the key as held
        keys = 4'b1000;
        start_frame();
        wait_done();
    end
    write_chart(0, 0, NOTE_SHORT, 1000);
    keys = 4'b1000;
    start_frame();
    check_value("judge_valid after new_frame", judge_valid, 1);
    check_value($sformatf("lane d grade at delta %0d", delta), judge_grade[7:6],
                expected_grade(delta, edge_wanted));
    check_value("grades of empty lanes", judge_grade[5:0], 0);
    @(negedge clk);
    check_value("judge_valid one cycle later", judge_valid, 0);
    wait_done();
    keys = '0;
endtask

task automatic judgement_windows();
    judge_case(40, 1'b1);
    judge_case(30, 1'b1);
    judge_case(20, 1'b1);
    judge_case(10, 1'b1);
    judge_case(0, 1'b1);
    judge_case(10, 1'b0);
endtask

task automatic pointer_advance();
    apply_reset();
    clear_chart();
    keys = '0;
    write_chart(1, 0, NOTE_SHORT, 100);
    write_chart(1, 1, NOTE_SHORT, 110);
    un_time = 16'd90;
    keys    = 4'b0100;
    start_frame();
    check_value("lane f grade on hit", judge_grade[5:4], expected_grade(10, 1'b1));
    wait_done();
    clear_logs();
    // key still held so the new head is not judged
    start_frame();
    check_value("lane f grade while held", judge_grade[5:4], expected_grade(20, 1'b0));
    wait_done();
    add_expected(1, 110, 90, 1'b0);
    compare_log();
    keys = '0;
endtask

task automatic back_pressure_frames();
    apply_reset();
    clear_chart();
    clear_logs();
    keys = '0;
    write_chart(1, 0, NOTE_SHORT, 100);
    write_chart(3, 0, NOTE_SHORT, 95);
    un_time   = 16'd90;
    max_delay = 0;
    add_expected(1, 100, 90, 1'b0);
    add_expected(3, 95, 90, 1'b0);
    start_frame();
    wait_done();
    compare_log();
    log_addr.delete();
    log_data.delete();
    log_be.delete();
    max_delay = MAX_DELAY;
    bp_enable = 1'b1;
    // bus busy before the first word too
    wait_hold = 4;
    start_frame();
    wait_done();
    compare_log();
    bp_enable = 1'b0;
    max_delay = 3;
endtask

`endif

// File: tests/tb_note_draw.sv
`timescale 1ns/1ps

module tb_note_draw
    import sprite_pkg::*;
();

    localparam int MAX_DELAY      = 12;
    localparam int SPRITE_WORDS   = 72;
    // words drawn over all tests times the worst cost of one word
    localparam int EXPECTED_WORDS = 324;
    localparam int TIMEOUT_CYCLES = EXPECTED_WORDS * (MAX_DELAY + 10) + 3000;

    logic         clk;
    logic         reset;
    logic         new_frame;
    logic         frame_flip;
    logic [15:0]  un_time;
    logic [3:0]   keys;
    logic         chart_wr;
    logic [5:0]   chart_addr;
    logic [15:0]  chart_data;
    logic         ram_wr;
    logic [6:0]   ram_wraddr;
    logic [127:0] ram_data;
    logic         sdram_wait;
    logic         sdram_ac;
    logic         sdram_wr;
    logic [21:0]  sdram_addr;
    logic [127:0] sdram_data;
    logic [15:0]  sdram_be;
    logic         busy;
    logic         done;
    logic         judge_valid;
    logic [7:0]   judge_grade;

    int           cycle_count = 0;
    int           max_delay;
    int           ac_wait;
    int           wait_hold;
    logic         bp_enable;
    logic [127:0] sprite_mem [SPRITE_WORDS];
    logic [21:0]  log_addr [$];
    logic [127:0] log_data [$];
    logic [15:0]  log_be [$];
    logic [21:0]  exp_addr [$];
    logic [127:0] exp_data [$];
    logic [15:0]  exp_be [$];

    `include "tb_tasks.svh"

    note_draw_top uut (.*);

    initial
        clk = 1'b0;
    always #50 clk = ~clk;

    // SDRAM model accepts each word after a random delay
    always @(negedge clk)
    begin
        check_value("sdram_wr raised while sdram_wait is high", sdram_wr & sdram_wait, 0);
        if (sdram_ac)
            sdram_ac = 1'b0;
        else if (sdram_wr)
        begin
            if (ac_wait > 0)
                ac_wait--;
            else
            begin
                log_addr.push_back(sdram_addr);
                log_data.push_back(sdram_data);
                log_be.push_back(sdram_be);
                sdram_ac = 1'b1;
                ac_wait  = $urandom % (max_delay + 1);
                if (bp_enable && ($urandom % 2 == 1))
                    wait_hold = 1 + $urandom % 5;
            end
        end
        sdram_wait = wait_hold > 0;
        if (wait_hold > 0)
            wait_hold--;
    end

    always @(posedge clk)
    begin
        cycle_count++;
        if (cycle_count > TIMEOUT_CYCLES)
        begin
            $display("run did not finish within %0d clock cycles", TIMEOUT_CYCLES);
            $display("TEST FAIL");
            $fatal(1, "timeout");
        end
    end

    initial
    begin
        void'($urandom(32'hbd50_55a7));
        reset      = 1'b1;
        new_frame  = 1'b0;
        frame_flip = 1'b0;
        un_time    = '0;
        keys       = '0;
        chart_wr   = 1'b0;
        chart_addr = '0;
        chart_data = '0;
        ram_wr     = 1'b0;
        ram_wraddr = '0;
        ram_data   = '0;
        sdram_wait = 1'b0;
        sdram_ac   = 1'b0;
        max_delay  = 3;
        ac_wait    = 0;
        wait_hold  = 0;
        bp_enable  = 1'b0;

        reset_state_low();
        load_sprites();
        single_note_frame();
        flipped_frame();
        judgement_windows();
        pointer_advance();
        back_pressure_frames();

        $display("TEST PASS");
        $finish;
    end

endmodule

// File: files.f
+incdir+tests
design/sprite_pkg.sv
design/note_tracker.sv
design/sprite_store.sv
design/blit_sequencer.sv
design/note_draw_top.sv
tests/tb_note_draw.sv
